//--- ssa_pkg.sv
/*
  static straight allocator shared definitions
  sizes, port directions, flit/status/event structs and the straight-port map
*/
package ssa_pkg;

    // router geometry
    localparam int num_ports = 5;
    localparam int num_vcs   = 4;
    localparam int num_pv    = num_ports * num_vcs;

    // flit layout
    localparam int payload_w = 32;
    localparam int dest_lsb  = 16;  // first bit of the one-hot destination code

    // mesh port directions
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    // one flit as seen on an input port
    typedef struct packed {
        logic                 hdr_flg;
        logic                 tail_flg;
        logic [num_vcs-1:0]   vc;        // one-hot input VC
        logic [payload_w-1:0] payload;
    } flit_t;

    // per input VC state from the router's VC logic
    typedef struct packed {
        logic                 request;       // normal allocator request pending
        logic                 ovc_not_full;  // assigned OVC has credit
        logic                 ovc_assigned;
        logic                 assigned_ss;   // assigned OVC sits on the straight port
        logic [num_ports-2:0] dest;          // assigned route, receiving port removed
    } ivc_status_t;

    // strobes for one input VC
    typedef struct packed {
        logic credit_dec;
        logic ovc_alloc;
        logic ovc_release;
    } vc_event_t;

    // opposite port, local maps onto itself
    function automatic port_e ss_port_of(port_e p);
        case (p)
            port_east:  return port_west;
            port_west:  return port_east;
            port_north: return port_south;
            port_south: return port_north;
            default:    return port_local;
        endcase
    endfunction

endpackage

//--- ssa_hdr_decode.sv
/*
  header decode for one input port of the straight allocator
  pulls flags and VC out of the flit and expands destination codes to one-hot
*/
`timescale 1ns/1ps

module ssa_hdr_decode #(
    parameter ssa_pkg::port_e sw_loc = ssa_pkg::port_east
) (
    input  ssa_pkg::flit_t                                          flit,
    input  logic [ssa_pkg::num_vcs-1:0][ssa_pkg::num_ports-2:0]     assigned_dest,
    output logic                                                    hdr_flg,
    output logic                                                    tail_flg,
    output logic [ssa_pkg::num_vcs-1:0]                             vc_onehot,
    output logic [ssa_pkg::num_ports-1:0]                           hdr_dest_onehot,
    output logic [ssa_pkg::num_vcs-1:0][ssa_pkg::num_ports-1:0]     assigned_dest_onehot
);
    import ssa_pkg::*;

    // code leaves out the receiving port, so put a zero back at sw_loc
    function automatic logic [num_ports-1:0] add_sw_loc(logic [num_ports-2:0] code);
        logic [num_ports-1:0] oh;
        oh = '0;
        for (int k = 0; k < num_ports-1; k++) begin
            if (k < int'(sw_loc)) begin
                oh[k] = code[k];
            end else begin
                oh[k+1] = code[k];  // shifted past the receiving port
            end
        end
        return oh;
    endfunction

    logic [num_ports-2:0] hdr_dest_code;

    assign hdr_flg       = flit.hdr_flg;
    assign tail_flg      = flit.tail_flg;
    assign vc_onehot     = flit.vc;
    assign hdr_dest_code = flit.payload[dest_lsb +: num_ports-1];

    assign hdr_dest_onehot = add_sw_loc(hdr_dest_code);

    // routes already held by each IVC
    always_comb begin
        for (int v = 0; v < num_vcs; v++) begin
            assigned_dest_onehot[v] = add_sw_loc(assigned_dest[v]);
        end
    end

endmodule

//--- ssa_vc_check.sv
/*
  straight output VC readiness for one input port
  also qualifies the flit write per VC
*/
`timescale 1ns/1ps

module ssa_vc_check #(
    parameter ssa_pkg::port_e sw_loc = ssa_pkg::port_east
) (
    input  logic                                                flit_we,
    input  logic [ssa_pkg::num_vcs-1:0]                         vc_onehot,
    input  logic [ssa_pkg::num_vcs-1:0][ssa_pkg::num_ports-1:0] assigned_dest_onehot,
    input  ssa_pkg::ivc_status_t [ssa_pkg::num_vcs-1:0]         ivc_status,
    input  logic [ssa_pkg::num_vcs-1:0]                         ovc_available_ss,
    output logic [ssa_pkg::num_vcs-1:0]                         ss_ovc_ready,
    output logic [ssa_pkg::num_vcs-1:0]                         ss_vc_wr
);
    import ssa_pkg::*;

    localparam port_e ss_port = ss_port_of(sw_loc);

    logic [num_vcs-1:0] assigned_ready;

    always_comb begin
        for (int v = 0; v < num_vcs; v++) begin
            // held route must point straight and sit on the straight OVC
            assigned_ready[v] = assigned_dest_onehot[v][ss_port]
                              & ivc_status[v].assigned_ss
                              & ivc_status[v].ovc_not_full;

            if (ivc_status[v].ovc_assigned) begin
                ss_ovc_ready[v] = assigned_ready[v];
            end else begin
                ss_ovc_ready[v] = ovc_available_ss[v];  // same VC index on the straight port
            end
        end
    end

    assign ss_vc_wr = {num_vcs{flit_we}} & vc_onehot;

    // upstream router must tag each flit with exactly one VC
    always_comb begin
        if (flit_we) begin
            assert ($onehot0(vc_onehot))
                else $error("flit written with more than one VC bit set");
        end
    end

endmodule

//--- ssa_ctrl.sv
/*
  bypass control of the straight allocator
  forms per-IVC permission and event strobes, registers the straight flit write
*/
`timescale 1ns/1ps

module ssa_ctrl (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [ssa_pkg::num_ports-1:0]                           hdr_flg,
    input  logic [ssa_pkg::num_ports-1:0]                           tail_flg,
    input  logic [ssa_pkg::num_ports-1:0][ssa_pkg::num_ports-1:0]   hdr_dest_onehot,
    input  logic [ssa_pkg::num_ports-1:0][ssa_pkg::num_vcs-1:0]     ss_ovc_ready,
    input  logic [ssa_pkg::num_ports-1:0][ssa_pkg::num_vcs-1:0]     ss_vc_wr,
    input  logic [ssa_pkg::num_ports-1:0][ssa_pkg::num_vcs-1:0]     ivc_request,
    input  logic [ssa_pkg::num_ports-1:0]                           any_ivc_sw_request_granted,
    input  logic [ssa_pkg::num_ports-1:0]                           any_ovc_granted_in_outport,
    output ssa_pkg::vc_event_t [ssa_pkg::num_pv-1:0]                vc_event,
    output logic [ssa_pkg::num_ports-1:0]                           ssa_flit_wr
);
    import ssa_pkg::*;

    logic [num_ports-1:0] flit_wr_next;  // indexed by straight output port

    always_comb begin
        port_e ss;
        logic  to_ss;
        logic  permit;
        logic  fire;
        int    i;

        vc_event     = '0;
        flit_wr_next = '0;

        for (int p = 0; p < num_ports; p++) begin
            ss    = ss_port_of(port_e'(p));
            to_ss = hdr_dest_onehot[p][ss];
            for (int v = 0; v < num_vcs; v++) begin
                i = p * num_vcs + v;

                // input port idle, straight port free, nothing queued, OVC ready
                permit = ss_ovc_ready[p][v]
                       & ~ivc_request[p][v]
                       & ~any_ivc_sw_request_granted[p]
                       & ~any_ovc_granted_in_outport[ss];
                fire   = permit & ss_vc_wr[p][v];

                if (port_e'(p) != port_local) begin
                    vc_event[i].credit_dec  = fire & ~(hdr_flg[p] & ~to_ss);
                    vc_event[i].ovc_alloc   = fire & hdr_flg[p] & to_ss;
                    vc_event[i].ovc_release = fire & tail_flg[p];
                end

                flit_wr_next[ss] = flit_wr_next[ss] | vc_event[i].credit_dec;
            end
        end
    end

    // flit leaves on the straight port one cycle after the credit strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ssa_flit_wr <= '0;
        end else begin
            ssa_flit_wr <= flit_wr_next;
        end
    end

    for (genvar i = 0; i < num_pv; i++) begin : g_chk
        a_alloc_takes_credit: assert property (
            @(posedge clk) disable iff (reset)
            vc_event[i].ovc_alloc |-> vc_event[i].credit_dec
        ) else $error("OVC allocated without credit decrease on IVC %0d", i);
    end

    a_local_quiet: assert property (
        @(posedge clk) disable iff (reset)
        vc_event[num_vcs-1:0] == '0
    ) else $error("straight event on a local IVC");

endmodule

//--- ssa_out_map.sv
/*
  maps per-IVC straight events onto output VC indices
  and builds the per-IVC grant vectors
*/
`timescale 1ns/1ps

module ssa_out_map (
    input  ssa_pkg::vc_event_t [ssa_pkg::num_pv-1:0]            vc_event,
    output logic [ssa_pkg::num_pv-1:0]                          ovc_allocated,
    output logic [ssa_pkg::num_pv-1:0]                          ovc_released,
    output logic [ssa_pkg::num_pv-1:0]                          decreased_credit_in_ss_ovc,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_num_getting_sw_grant,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_num_getting_ovc_grant,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_reset,
    output logic [ssa_pkg::num_pv-1:0][ssa_pkg::num_vcs-1:0]    granted_ovc_num
);
    import ssa_pkg::*;

    always_comb begin
        port_e ss;
        int    v;
        int    o;

        ovc_allocated              = '0;
        ovc_released               = '0;
        decreased_credit_in_ss_ovc = '0;
        ivc_num_getting_sw_grant   = '0;
        ivc_num_getting_ovc_grant  = '0;
        ivc_reset                  = '0;
        granted_ovc_num            = '0;

        for (int i = 0; i < num_pv; i++) begin
            ss = ss_port_of(port_e'(i / num_vcs));
            v  = i % num_vcs;
            o  = int'(ss) * num_vcs + v;  // same VC index on the straight port

            if (ss != port_local) begin
                // input side, indexed by the IVC itself
                ivc_num_getting_sw_grant[i]  = vc_event[i].credit_dec;
                ivc_num_getting_ovc_grant[i] = vc_event[i].ovc_alloc;
                ivc_reset[i]                 = vc_event[i].ovc_release;
                granted_ovc_num[i][v]        = vc_event[i].ovc_alloc;

                // output side
                decreased_credit_in_ss_ovc[o] = vc_event[i].credit_dec;
                ovc_allocated[o]              = vc_event[i].ovc_alloc;
                ovc_released[o]               = vc_event[i].ovc_release;
            end
        end
    end

endmodule

//--- ssa_top.sv
/*
  static straight allocator for a five-port mesh router
  lets straight-through flits skip VC and switch allocation
*/
`timescale 1ns/1ps

module ssa_top (
    input  logic                                                clk,
    input  logic                                                reset,
    input  ssa_pkg::flit_t [ssa_pkg::num_ports-1:0]             flit_in,
    input  logic [ssa_pkg::num_ports-1:0]                       flit_in_we,
    input  logic [ssa_pkg::num_ports-1:0]                       any_ivc_sw_request_granted,
    input  logic [ssa_pkg::num_ports-1:0]                       any_ovc_granted_in_outport,
    input  logic [ssa_pkg::num_pv-1:0]                          ovc_available,
    input  ssa_pkg::ivc_status_t [ssa_pkg::num_pv-1:0]          ivc_status,
    output logic [ssa_pkg::num_pv-1:0]                          ovc_allocated,
    output logic [ssa_pkg::num_pv-1:0]                          ovc_released,
    output logic [ssa_pkg::num_pv-1:0]                          decreased_credit_in_ss_ovc,
    output logic [ssa_pkg::num_pv-1:0][ssa_pkg::num_vcs-1:0]    granted_ovc_num,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_num_getting_sw_grant,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_num_getting_ovc_grant,
    output logic [ssa_pkg::num_pv-1:0]                          ivc_reset,
    output logic [ssa_pkg::num_ports-1:0]                       ssa_flit_wr
);
    import ssa_pkg::*;

    logic [num_ports-1:0]                hdr_flg;
    logic [num_ports-1:0]                tail_flg;
    logic [num_ports-1:0][num_ports-1:0] hdr_dest_onehot;
    logic [num_ports-1:0][num_vcs-1:0]   ss_ovc_ready;
    logic [num_ports-1:0][num_vcs-1:0]   ss_vc_wr;
    logic [num_ports-1:0][num_vcs-1:0]   ivc_request;
    vc_event_t [num_pv-1:0]              vc_event;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        localparam port_e ss = ss_port_of(port_e'(p));

        for (genvar v = 0; v < num_vcs; v++) begin : g_req
            assign ivc_request[p][v] = ivc_status[p*num_vcs+v].request;
        end

        if (p == int'(port_local)) begin : g_local
            // local port never bypasses
            assign hdr_flg[p]         = 1'b0;
            assign tail_flg[p]        = 1'b0;
            assign hdr_dest_onehot[p] = '0;
            assign ss_ovc_ready[p]    = '0;
            assign ss_vc_wr[p]        = '0;
        end else begin : g_ss
            logic [num_vcs-1:0]                  vc_onehot;
            logic [num_vcs-1:0][num_ports-2:0]   assigned_dest;
            logic [num_vcs-1:0][num_ports-1:0]   assigned_dest_onehot;

            for (genvar v = 0; v < num_vcs; v++) begin : g_dest
                assign assigned_dest[v] = ivc_status[p*num_vcs+v].dest;
            end

            ssa_hdr_decode #(.sw_loc(port_e'(p))) u_decode (
                .flit                 (flit_in[p]),
                .assigned_dest        (assigned_dest),
                .hdr_flg              (hdr_flg[p]),
                .tail_flg             (tail_flg[p]),
                .vc_onehot            (vc_onehot),
                .hdr_dest_onehot      (hdr_dest_onehot[p]),
                .assigned_dest_onehot (assigned_dest_onehot)
            );

            ssa_vc_check #(.sw_loc(port_e'(p))) u_check (
                .flit_we              (flit_in_we[p]),
                .vc_onehot            (vc_onehot),
                .assigned_dest_onehot (assigned_dest_onehot),
                .ivc_status           (ivc_status[p*num_vcs +: num_vcs]),
                .ovc_available_ss     (ovc_available[int'(ss)*num_vcs +: num_vcs]),
                .ss_ovc_ready         (ss_ovc_ready[p]),
                .ss_vc_wr             (ss_vc_wr[p])
            );
        end
    end

    ssa_ctrl u_ctrl (
        .clk                        (clk),
        .reset                      (reset),
        .hdr_flg                    (hdr_flg),
        .tail_flg                   (tail_flg),
        .hdr_dest_onehot            (hdr_dest_onehot),
        .ss_ovc_ready               (ss_ovc_ready),
        .ss_vc_wr                   (ss_vc_wr),
        .ivc_request                (ivc_request),
        .any_ivc_sw_request_granted (any_ivc_sw_request_granted),
        .any_ovc_granted_in_outport (any_ovc_granted_in_outport),
        .vc_event                   (vc_event),
        .ssa_flit_wr                (ssa_flit_wr)
    );

    ssa_out_map u_out_map (
        .vc_event                   (vc_event),
        .ovc_allocated              (ovc_allocated),
        .ovc_released               (ovc_released),
        .decreased_credit_in_ss_ovc (decreased_credit_in_ss_ovc),
        .ivc_num_getting_sw_grant   (ivc_num_getting_sw_grant),
        .ivc_num_getting_ovc_grant  (ivc_num_getting_ovc_grant),
        .ivc_reset                  (ivc_reset),
        .granted_ovc_num            (granted_ovc_num)
    );

endmodule

//--- tb_ssa.sv
/*
  testbench for the static straight allocator
  directed bypass cases plus a seeded random sweep against a reference model
*/
`timescale 1ns/1ps

module tb_ssa;
    import ssa_pkg::*;

    logic                               clk;
    logic                               reset;
    flit_t [num_ports-1:0]              flit_in;
    logic [num_ports-1:0]               flit_in_we;
    logic [num_ports-1:0]               any_ivc_sw_request_granted;
    logic [num_ports-1:0]               any_ovc_granted_in_outport;
    logic [num_pv-1:0]                  ovc_available;
    ivc_status_t [num_pv-1:0]           ivc_status;
    logic [num_pv-1:0]                  ovc_allocated;
    logic [num_pv-1:0]                  ovc_released;
    logic [num_pv-1:0]                  decreased_credit_in_ss_ovc;
    logic [num_pv-1:0][num_vcs-1:0]     granted_ovc_num;
    logic [num_pv-1:0]                  ivc_num_getting_sw_grant;
    logic [num_pv-1:0]                  ivc_num_getting_ovc_grant;
    logic [num_pv-1:0]                  ivc_reset;
    logic [num_ports-1:0]               ssa_flit_wr;

    // expected values from the reference model
    logic [num_pv-1:0]                  exp_alloc;
    logic [num_pv-1:0]                  exp_rel;
    logic [num_pv-1:0]                  exp_credit;
    logic [num_pv-1:0]                  exp_sw;
    logic [num_pv-1:0]                  exp_ovc;
    logic [num_pv-1:0]                  exp_rst;
    logic [num_pv-1:0][num_vcs-1:0]     exp_granted;
    logic [num_ports-1:0]               exp_wr_next;
    logic [num_ports-1:0]               wr_pending;  // registered write due after next edge
    logic [31:0]                        lcg_state;

    ssa_top DUT (
        .clk                        (clk),
        .reset                      (reset),
        .flit_in                    (flit_in),
        .flit_in_we                 (flit_in_we),
        .any_ivc_sw_request_granted (any_ivc_sw_request_granted),
        .any_ovc_granted_in_outport (any_ovc_granted_in_outport),
        .ovc_available              (ovc_available),
        .ivc_status                 (ivc_status),
        .ovc_allocated              (ovc_allocated),
        .ovc_released               (ovc_released),
        .decreased_credit_in_ss_ovc (decreased_credit_in_ss_ovc),
        .granted_ovc_num            (granted_ovc_num),
        .ivc_num_getting_sw_grant   (ivc_num_getting_sw_grant),
        .ivc_num_getting_ovc_grant  (ivc_num_getting_ovc_grant),
        .ivc_reset                  (ivc_reset),
        .ssa_flit_wr                (ssa_flit_wr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #20000;
        $display("simulation did not finish within the time limit");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // east and west face each other, so do north and south
    function automatic int straight_of(int p);
        case (p)
            1: return 3;
            3: return 1;
            2: return 4;
            4: return 2;
            default: return 0;
        endcase
    endfunction

    // 4-bit code to 5-bit one-hot, zero at the receiving port
    function automatic logic [num_ports-1:0] expand_code(logic [num_ports-2:0] code, int loc);
        logic [num_ports-1:0] oh;
        oh = '0;
        for (int k = 0; k < num_ports; k++) begin
            if (k < loc) begin
                oh[k] = code[k];
            end else if (k > loc) begin
                oh[k] = code[k-1];
            end
        end
        return oh;
    endfunction

    function automatic logic [num_ports-2:0] dest_code(int rx, int target);
        logic [num_ports-2:0] code;
        code = '0;
        if (target < rx) begin
            code[target] = 1'b1;
        end else begin
            code[target-1] = 1'b1;
        end
        return code;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic clear_inputs();
        flit_in                    = '0;
        flit_in_we                 = '0;
        any_ivc_sw_request_granted = '0;
        any_ovc_granted_in_outport = '0;
        ovc_available              = '0;
        ivc_status                 = '0;
    endtask

    task automatic predict();
        int                   s;
        int                   i;
        int                   o;
        logic                 to_ss;
        logic                 ready;
        logic                 fire;
        logic [num_ports-1:0] hdr_oh;
        logic [num_ports-1:0] asg_oh;

        exp_alloc   = '0;
        exp_rel     = '0;
        exp_credit  = '0;
        exp_sw      = '0;
        exp_ovc     = '0;
        exp_rst     = '0;
        exp_granted = '0;
        exp_wr_next = '0;
        for (int p = 1; p < num_ports; p++) begin  // local port never bypasses
            s      = straight_of(p);
            hdr_oh = expand_code(flit_in[p].payload[dest_lsb +: num_ports-1], p);
            to_ss  = hdr_oh[s];
            for (int v = 0; v < num_vcs; v++) begin
                i      = p * num_vcs + v;
                o      = s * num_vcs + v;
                asg_oh = expand_code(ivc_status[i].dest, p);
                if (ivc_status[i].ovc_assigned) begin
                    ready = asg_oh[s] & ivc_status[i].assigned_ss & ivc_status[i].ovc_not_full;
                end else begin
                    ready = ovc_available[o];
                end
                fire = ready & ~ivc_status[i].request & ~any_ivc_sw_request_granted[p]
                     & ~any_ovc_granted_in_outport[s] & flit_in_we[p] & flit_in[p].vc[v];
                exp_sw[i]         = fire & (~flit_in[p].hdr_flg | to_ss);
                exp_ovc[i]        = fire & flit_in[p].hdr_flg & to_ss;
                exp_rst[i]        = fire & flit_in[p].tail_flg;
                exp_granted[i][v] = exp_ovc[i];
                exp_credit[o]     = exp_sw[i];
                exp_alloc[o]      = exp_ovc[i];
                exp_rel[o]        = exp_rst[i];
                exp_wr_next[s]    = exp_wr_next[s] | exp_sw[i];
            end
        end
    endtask

    task automatic settle_and_check();
        #1;
        // new inputs must not reach the registered write before the next edge
        check("ssa_flit_wr", 128'(ssa_flit_wr), 128'(wr_pending));
        predict();
        check("ovc_allocated", 128'(ovc_allocated), 128'(exp_alloc));
        check("ovc_released", 128'(ovc_released), 128'(exp_rel));
        check("decreased_credit_in_ss_ovc", 128'(decreased_credit_in_ss_ovc), 128'(exp_credit));
        check("granted_ovc_num", 128'(granted_ovc_num), 128'(exp_granted));
        check("ivc_num_getting_sw_grant", 128'(ivc_num_getting_sw_grant), 128'(exp_sw));
        check("ivc_num_getting_ovc_grant", 128'(ivc_num_getting_ovc_grant), 128'(exp_ovc));
        check("ivc_reset", 128'(ivc_reset), 128'(exp_rst));
        wr_pending = exp_wr_next;
    endtask

    // falling edge, registered write from the previous inputs is settled here
    task automatic next_cycle();
        @(negedge clk);
        check("ssa_flit_wr", 128'(ssa_flit_wr), 128'(wr_pending));
    endtask

    task automatic wait_flit_wr(input int port, input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ssa_flit_wr[port] && cycles < limit);
        if (!ssa_flit_wr[port]) begin
            $display("no straight flit write on port %0d within %0d cycles", port, limit);
            $display("Simulation FAILED");
            $fatal(1, "timeout waiting for flit write");
        end
        check("ssa_flit_wr latency", 128'(cycles), 128'(1));
    endtask

    task automatic check_all_zero();
        check("ovc_allocated", 128'(ovc_allocated), 128'(0));
        check("ovc_released", 128'(ovc_released), 128'(0));
        check("decreased_credit_in_ss_ovc", 128'(decreased_credit_in_ss_ovc), 128'(0));
        check("granted_ovc_num", 128'(granted_ovc_num), 128'(0));
        check("ivc_num_getting_sw_grant", 128'(ivc_num_getting_sw_grant), 128'(0));
        check("ivc_num_getting_ovc_grant", 128'(ivc_num_getting_ovc_grant), 128'(0));
        check("ivc_reset", 128'(ivc_reset), 128'(0));
        check("ssa_flit_wr", 128'(ssa_flit_wr), 128'(0));
    endtask

    // header on east VC 2 heading west
    task automatic drive_east_header(input int target);
        flit_in[port_east].hdr_flg                       = 1'b1;
        flit_in[port_east].vc                            = 4'b0100;
        flit_in[port_east].payload[dest_lsb +: num_ports-1] = dest_code(int'(port_east), target);
        flit_in_we[port_east]                            = 1'b1;
        ovc_available[int'(port_west)*num_vcs + 2]       = 1'b1;
    endtask

    task automatic test_east_header();
        next_cycle();
        drive_east_header(int'(port_west));
        settle_and_check();
        check("ovc_allocated", 128'(ovc_allocated), 128'(20'd1 << (int'(port_west)*num_vcs + 2)));
        check("decreased_credit_in_ss_ovc", 128'(decreased_credit_in_ss_ovc),
              128'(20'd1 << (int'(port_west)*num_vcs + 2)));
        check("ivc_num_getting_sw_grant", 128'(ivc_num_getting_sw_grant), 128'(20'h00040));
        check("ivc_num_getting_ovc_grant", 128'(ivc_num_getting_ovc_grant), 128'(20'h00040));
        check("granted_ovc_num[6]", 128'(granted_ovc_num[6]), 128'(4'b0100));
        wait_flit_wr(int'(port_west), 4);
        next_cycle();
        clear_inputs();
        settle_and_check();
    endtask

    task automatic test_blocking();
        for (int c = 0; c < 3; c++) begin
            next_cycle();
            drive_east_header(int'(port_west));
            case (c)
                0: any_ivc_sw_request_granted[port_east] = 1'b1;
                1: any_ovc_granted_in_outport[port_west] = 1'b1;
                default: ivc_status[6].request = 1'b1;
            endcase
            settle_and_check();
            check("ivc_num_getting_sw_grant", 128'(ivc_num_getting_sw_grant), 128'(0));
            check("ovc_allocated", 128'(ovc_allocated), 128'(0));
            next_cycle();
            clear_inputs();
            settle_and_check();
        end
    endtask

    // north VC 1 already holds the straight south OVC
    task automatic test_north_body_tail();
        next_cycle();
        ivc_status[9].ovc_assigned = 1'b1;
        ivc_status[9].assigned_ss  = 1'b1;
        ivc_status[9].ovc_not_full = 1'b1;
        ivc_status[9].dest         = dest_code(int'(port_north), int'(port_south));
        flit_in[port_north].vc     = 4'b0010;
        flit_in_we[port_north]     = 1'b1;
        settle_and_check();
        check("decreased_credit_in_ss_ovc", 128'(decreased_credit_in_ss_ovc), 128'(20'd1 << 17));
        check("ovc_released", 128'(ovc_released), 128'(0));
        check("ovc_allocated", 128'(ovc_allocated), 128'(0));
        next_cycle();
        flit_in[port_north].tail_flg = 1'b1;
        settle_and_check();
        check("decreased_credit_in_ss_ovc", 128'(decreased_credit_in_ss_ovc), 128'(20'd1 << 17));
        check("ovc_released", 128'(ovc_released), 128'(20'd1 << 17));
        check("ivc_reset", 128'(ivc_reset), 128'(20'd1 << 9));
        check("ovc_allocated", 128'(ovc_allocated), 128'(0));
        next_cycle();
        clear_inputs();
        settle_and_check();
    endtask

    task automatic test_no_bypass();
        next_cycle();
        drive_east_header(int'(port_north));  // turns, so not straight
        ovc_available = '1;
        settle_and_check();
        check_all_zero();
        next_cycle();
        clear_inputs();
        flit_in[port_local].hdr_flg  = 1'b1;
        flit_in[port_local].tail_flg = 1'b1;
        flit_in[port_local].vc       = 4'b0001;
        flit_in_we[port_local]       = 1'b1;
        ovc_available                = '1;
        settle_and_check();
        check_all_zero();
        next_cycle();
        clear_inputs();
        settle_and_check();
    endtask

    task automatic randomize_inputs();
        logic [31:0] r;
        logic [31:0] rs;
        logic [2:0]  n;

        for (int p = 0; p < num_ports; p++) begin
            r                    = lcg_next();
            flit_in[p].payload   = lcg_next();
            flit_in[p].hdr_flg   = r[0];
            flit_in[p].tail_flg  = r[1];
            n                    = r[10:8] % 3'd5;
            flit_in[p].vc        = (n == 3'd0) ? 4'b0000 : 4'(4'b0001 << (n - 3'd1));
            flit_in_we[p]        = r[2] | r[3];
            for (int v = 0; v < num_vcs; v++) begin
                rs                              = lcg_next();
                ivc_status[p*num_vcs + v]         = rs[7:0];
                ivc_status[p*num_vcs + v].request = &rs[9:8];  // mostly idle
            end
        end
        r                          = lcg_next();
        any_ivc_sw_request_granted = r[4:0] & r[9:5];
        any_ovc_granted_in_outport = r[14:10] & r[19:15];
        r                          = lcg_next();
        ovc_available              = r[num_pv-1:0];
    endtask

    task automatic test_random_sweep();
        for (int c = 0; c < 200; c++) begin
            next_cycle();
            randomize_inputs();
            settle_and_check();
        end
        next_cycle();
        clear_inputs();
        settle_and_check();
    endtask

    initial begin
        clear_inputs();
        reset      = 1'b1;
        lcg_state  = 32'hd8a9_7dcd;
        wr_pending = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_all_zero();

        test_east_header();
        test_blocking();
        test_north_body_tail();
        test_no_bypass();
        test_random_sweep();
        next_cycle();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- project.f
ssa_pkg.sv
ssa_hdr_decode.sv
ssa_vc_check.sv
ssa_ctrl.sv
ssa_out_map.sv
ssa_top.sv
tb_ssa.sv

//--- run.sh
#!/bin/sh
# build and run the straight allocator testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f project.f --top-module tb_ssa -o sim_ssa \
    && ./obj_dir/sim_ssa \
    || { echo "build or simulation run failed"; exit 1; }
